/* hdl/ifuPkg.sv */
package ifuPkg;

  ////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////

  // data and address width of the core
  localparam int XLEN = 32;

  // addi x0,x0,0, loaded into a stage on a bubble
  localparam logic [31:0] NOP = 32'h0000_0013;

  // major opcodes of the base ISA
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_OPIMM  = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;

  ////////////////////////////////////////
  // instruction word
  ////////////////////////////////////////

  // standard R-type field layout, other formats overlay it
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } stdFieldsT;

  // two halfword parcels, lo is the one at the fetch address
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } parcelPairT;

  typedef union packed {
    stdFieldsT  std;
    parcelPairT comp;
  } instrWordU;

  // control-flow class, one hot or all zero
  typedef struct packed {
    logic call;
    logic ret;
    logic jumpReg;
    logic jump;
    logic branch;
  } instrClassT;

  ////////////////////////////////////////
  // stage and memory port bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcLink;
    instrWordU       instr;
    instrClassT      cls;
  } stageT;

  typedef struct packed {
    logic [XLEN-1:0] addr;
  } imemReqT;

  typedef struct packed {
    instrWordU data;
  } imemRspT;

endpackage

/* hdl/pcLogic.sv */
module pcLogic #(
  parameter logic [ifuPkg::XLEN-1:0] resetVector = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stallF,
  input  logic                    predWrongE,
  input  logic [ifuPkg::XLEN-1:0] pcCorrectE,
  input  logic                    retM,
  input  logic                    trapM,
  input  logic [ifuPkg::XLEN-1:0] privNextPcM,
  input  logic                    imemReady,
  input  ifuPkg::imemRspT         imemRsp,
  output logic                    imemValid,
  output ifuPkg::imemReqT         imemReq,
  output logic                    fetchDone,
  output logic                    redirect,
  output logic [ifuPkg::XLEN-1:0] pcF,
  output logic [ifuPkg::XLEN-1:0] pcPlus
);
  import ifuPkg::*;

  logic            rstQ;
  logic            privChange;
  logic            compF;
  logic            pcEn;
  logic [XLEN-1:0] pcNextRaw;
  logic [XLEN-1:0] pcNext;

  // delayed reset, holds the reset vector one more cycle
  always_ff @(posedge clk) begin
    rstQ <= rst;
  end

  // no requests during reset or the cycle after
  assign imemValid = ~rst & ~rstQ;
  assign imemReq   = '{addr: pcF};

  // a fetch only counts when F is free to move on
  // otherwise D would see the same word twice
  assign fetchDone = imemValid & imemReady & ~stallF;

  ////////////////////////////////////////
  // sequential address
  ////////////////////////////////////////

  // low parcel not ending in 11 means a 16-bit instruction
  assign compF  = imemRsp.data.comp.lo[1:0] != 2'b11;
  // +2 or +4
  assign pcPlus = pcF + {{(XLEN-3){1'b0}}, ~compF, compF, 1'b0};

  ////////////////////////////////////////
  // next PC select
  ////////////////////////////////////////

  assign privChange = retM | trapM;
  assign redirect   = predWrongE | privChange;

  // lowest to highest: sequential, execute, privileged, reset
  always_comb begin
    if (rstQ) begin
      pcNextRaw = resetVector;
    end else if (privChange) begin
      pcNextRaw = privNextPcM;
    end else if (predWrongE) begin
      pcNextRaw = pcCorrectE;
    end else begin
      pcNextRaw = pcPlus;
    end
  end

  // halfword alignment, bit 0 never reaches the PC
  assign pcNext = {pcNextRaw[XLEN-1:1], 1'b0};

  // redirect wins over stallF and an unfinished fetch
  assign pcEn = redirect | fetchDone | (~stallF & ~imemValid);

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= resetVector;
    end else if (pcEn) begin
      pcF <= pcNext;
    end
  end

endmodule

/* hdl/decompress.sv */
module decompress (
  input  logic [15:0]       parcel,
  output ifuPkg::instrWordU expanded,
  output logic              illegal
);
  import ifuPkg::*;

  logic [4:0]  rdFull;
  logic [4:0]  rs2Full;
  logic [4:0]  rdRs2C;
  logic [4:0]  rs1C;
  logic [11:0] ciImm;
  logic [11:0] memImm;
  logic [19:0] jImm;

  // full register fields of the CI/CR formats
  assign rdFull  = parcel[11:7];
  assign rs2Full = parcel[6:2];

  // three-bit fields map onto x8..x15
  // bits 4:2 are rd' for c.lw and rs2' for c.sw
  assign rdRs2C = {2'b01, parcel[4:2]};
  assign rs1C   = {2'b01, parcel[9:7]};

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  // signed 6-bit immediate of c.addi and c.li
  assign ciImm  = {{7{parcel[12]}}, parcel[6:2]};
  // word offset of c.lw and c.sw, zero extended
  assign memImm = {5'b0, parcel[5], parcel[12:10], parcel[6], 2'b00};
  // c.j / c.jal offset already in jal bit order
  // imm[20], imm[10:1], imm[11], imm[19:12]
  assign jImm   = {parcel[12], parcel[8], parcel[10:9], parcel[6], parcel[7],
                   parcel[2], parcel[11], parcel[5:3], {9{parcel[12]}}};

  ////////////////////////////////////////
  // expansion by funct3 and quadrant
  ////////////////////////////////////////

  always_comb begin
    expanded = NOP;
    illegal  = 1'b0;
    case ({parcel[15:13], parcel[1:0]})
      // c.lw
      5'b010_00: expanded = {memImm, rs1C, 3'b010, rdRs2C, OP_LOAD};
      // c.sw
      5'b110_00: expanded = {memImm[11:5], rdRs2C, rs1C, 3'b010, memImm[4:0], OP_STORE};
      // c.addi, c.nop falls out as addi x0,x0,0
      5'b000_01: expanded = {ciImm, rdFull, 3'b000, rdFull, OP_OPIMM};
      // c.jal links to x1
      5'b001_01: expanded = {jImm, 5'd1, OP_JAL};
      // c.li
      5'b010_01: expanded = {ciImm, 5'd0, 3'b000, rdFull, OP_OPIMM};
      5'b011_01: begin
        // rd of 2 is c.addi16sp, zero immediate is reserved
        if (rdFull == 5'd2 || {parcel[12], parcel[6:2]} == 6'd0) begin
          illegal = 1'b1;
        end else begin
          expanded = {{15{parcel[12]}}, parcel[6:2], rdFull, OP_LUI};
        end
      end
      // c.j
      5'b101_01: expanded = {jImm, 5'd0, OP_JAL};
      // c.beqz / c.bnez, bit 13 picks beq or bne
      5'b110_01, 5'b111_01: begin
        expanded = {{4{parcel[12]}}, parcel[6:5], parcel[2], 5'd0, rs1C, 2'b00,
                    parcel[13], parcel[11:10], parcel[4:3], parcel[12], OP_BRANCH};
      end
      5'b100_10: begin
        if (rs2Full != 5'd0) begin
          // c.add when bit 12 is set, else c.mv with rs1 = x0
          expanded = {7'd0, rs2Full, parcel[12] ? rdFull : 5'd0, 3'b000, rdFull, OP_OP};
        end else if (rdFull == 5'd0) begin
          // c.ebreak or the reserved c.jr x0
          illegal = 1'b1;
        end else begin
          // c.jalr links to x1, c.jr discards the link
          expanded = {12'd0, rdFull, 3'b000, parcel[12] ? 5'd1 : 5'd0, OP_JALR};
        end
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

/* hdl/decodeStage.sv */
module decodeStage #(
  parameter logic [ifuPkg::XLEN-1:0] resetVector = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stallD,
  input  logic                    flushD,
  input  logic                    fetchDone,
  input  logic                    redirect,
  input  logic [ifuPkg::XLEN-1:0] pcF,
  input  logic [ifuPkg::XLEN-1:0] pcPlus,
  input  ifuPkg::imemRspT         imemRsp,
  output ifuPkg::stageT           stageD,
  output logic                    illegalCompD
);
  import ifuPkg::*;

  logic            compF;
  logic            illegalF;
  logic            take;
  instrWordU       expandedF;
  instrWordU       fetchWord;
  logic            validD;
  logic            illegalQ;
  logic [XLEN-1:0] pcD;
  logic [XLEN-1:0] pcLinkD;
  instrWordU       instrD;
  instrClassT      clsD;
  logic            isJal;
  logic            isJalr;
  logic            linkRd;
  logic            linkRs1;

  ////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////

  assign compF = imemRsp.data.comp.lo[1:0] != 2'b11;

  decompress rvcExpand (
    .parcel  (imemRsp.data.comp.lo),
    .expanded(expandedF),
    .illegal (illegalF)
  );

  assign fetchWord = compF ? expandedF : imemRsp.data;

  // bubble on flush, empty fetch, or a PC redirect this cycle
  assign take = fetchDone & ~redirect & ~flushD;

  always_ff @(posedge clk) begin
    if (rst) begin
      validD   <= 1'b0;
      illegalQ <= 1'b0;
      instrD   <= NOP;
      pcD      <= resetVector;
      pcLinkD  <= resetVector;
    end else if (~stallD) begin
      validD   <= take;
      illegalQ <= compF & illegalF;
      instrD   <= take ? fetchWord : NOP;
      pcD      <= pcF;
      pcLinkD  <= pcPlus;
    end
  end

  // flag only meaningful alongside a live D entry
  assign illegalCompD = illegalQ & validD;

  ////////////////////////////////////////
  // control-flow class
  ////////////////////////////////////////

  assign isJal   = instrD.std.opcode == OP_JAL;
  assign isJalr  = instrD.std.opcode == OP_JALR;
  // x1 and x5 are the link registers
  assign linkRd  = (instrD.std.rd & 5'b11011) == 5'b00001;
  assign linkRs1 = (instrD.std.rs1 & 5'b11011) == 5'b00001;

  assign clsD.call    = (isJal | isJalr) & linkRd;
  assign clsD.ret     = isJalr & linkRs1 & ~linkRd;
  assign clsD.jumpReg = isJalr & ~linkRs1 & ~linkRd;
  assign clsD.jump    = isJal & ~linkRd;
  assign clsD.branch  = instrD.std.opcode == OP_BRANCH;

  always_comb begin
    stageD.valid  = validD;
    stageD.pc     = pcD;
    stageD.pcLink = pcLinkD;
    stageD.instr  = instrD;
    stageD.cls    = clsD;
  end

endmodule

/* hdl/execMemPipe.sv */
module execMemPipe (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stallE,
  input  logic                    stallM,
  input  logic                    flushE,
  input  logic                    flushM,
  input  ifuPkg::stageT           stageD,
  input  logic                    pcSrcE,
  input  logic [ifuPkg::XLEN-1:0] pcTargetE,
  output ifuPkg::stageT           stageE,
  output ifuPkg::stageT           stageM,
  output logic [ifuPkg::XLEN-1:0] pcCorrectE,
  output logic                    predWrongE,
  output logic                    instrMisalignedFaultM,
  output logic [ifuPkg::XLEN-1:0] instrMisalignedAdrM
);
  import ifuPkg::*;

  stageT [1:0] stageIn;
  logic  [1:0] stallV;
  logic  [1:0] flushV;
  logic        faultE;

  // empty slot, addresses kept for debug visibility
  function automatic stageT bubble(stageT s);
    stageT b;
    b       = s;
    b.valid = 1'b0;
    b.instr = NOP;
    b.cls   = '0;
    return b;
  endfunction

  ////////////////////////////////////////
  // E and M stage registers
  ////////////////////////////////////////

  // slot 0 is E, slot 1 is M
  assign stageIn = {stageE, stageD};
  assign stallV  = {stallM, stallE};
  assign flushV  = {flushM, flushE};

  for (genvar i = 0; i < 2; i++) begin : gStage
    stageT q;
    always_ff @(posedge clk) begin
      if (rst) begin
        q.valid <= 1'b0;
        q.instr <= NOP;
        q.cls   <= '0;
      end else if (~stallV[i]) begin
        q <= flushV[i] ? bubble(stageIn[i]) : stageIn[i];
      end
    end
  end

  assign stageE = gStage[0].q;
  assign stageM = gStage[1].q;

  // no predictor, so every fetch guessed not-taken
  assign predWrongE = pcSrcE;
  assign pcCorrectE = pcSrcE ? pcTargetE : stageE.pcLink;

  // taken redirect to an odd halfword
  assign faultE = pcSrcE & pcTargetE[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      instrMisalignedFaultM <= 1'b0;
    end else if (~stallM) begin
      instrMisalignedFaultM <= faultE;
    end
  end

  // raw target, bit 0 still set
  always_ff @(posedge clk) begin
    if (~stallM) begin
      instrMisalignedAdrM <= pcTargetE;
    end
  end

endmodule

/* hdl/ifu.sv */
module ifu #(
  parameter logic [ifuPkg::XLEN-1:0] resetVector = 32'h8000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  // hazard controls
  input  logic                    stallF,
  input  logic                    stallD,
  input  logic                    stallE,
  input  logic                    stallM,
  input  logic                    flushD,
  input  logic                    flushE,
  input  logic                    flushM,
  // execute redirect
  input  logic                    pcSrcE,
  input  logic [ifuPkg::XLEN-1:0] pcTargetE,
  // privileged redirect
  input  logic                    retM,
  input  logic                    trapM,
  input  logic [ifuPkg::XLEN-1:0] privNextPcM,
  // instruction memory
  output logic                    imemValid,
  output ifuPkg::imemReqT         imemReq,
  input  logic                    imemReady,
  input  ifuPkg::imemRspT         imemRsp,
  // pipeline view
  output logic [ifuPkg::XLEN-1:0] pcF,
  output ifuPkg::stageT           stageD,
  output ifuPkg::stageT           stageE,
  output ifuPkg::stageT           stageM,
  output logic                    predWrongE,
  output logic                    illegalCompD,
  output logic                    instrMisalignedFaultM,
  output logic [ifuPkg::XLEN-1:0] instrMisalignedAdrM
);
  import ifuPkg::*;

  logic [XLEN-1:0] pcCorrectE;
  logic [XLEN-1:0] pcPlus;
  logic            fetchDone;
  logic            redirect;

  ////////////////////////////////////////
  // fetch, decode, execute and memory
  ////////////////////////////////////////

  pcLogic #(.resetVector(resetVector)) fetchPc (
    .clk        (clk),
    .rst        (rst),
    .stallF     (stallF),
    .predWrongE (predWrongE),
    .pcCorrectE (pcCorrectE),
    .retM       (retM),
    .trapM      (trapM),
    .privNextPcM(privNextPcM),
    .imemReady  (imemReady),
    .imemRsp    (imemRsp),
    .imemValid  (imemValid),
    .imemReq    (imemReq),
    .fetchDone  (fetchDone),
    .redirect   (redirect),
    .pcF        (pcF),
    .pcPlus     (pcPlus)
  );

  decodeStage #(.resetVector(resetVector)) decStage (
    .clk         (clk),
    .rst         (rst),
    .stallD      (stallD),
    .flushD      (flushD),
    .fetchDone   (fetchDone),
    .redirect    (redirect),
    .pcF         (pcF),
    .pcPlus      (pcPlus),
    .imemRsp     (imemRsp),
    .stageD      (stageD),
    .illegalCompD(illegalCompD)
  );

  // correction and misaligned fault live with the E/M registers
  execMemPipe execMem (
    .clk                  (clk),
    .rst                  (rst),
    .stallE               (stallE),
    .stallM               (stallM),
    .flushE               (flushE),
    .flushM               (flushM),
    .stageD               (stageD),
    .pcSrcE               (pcSrcE),
    .pcTargetE            (pcTargetE),
    .stageE               (stageE),
    .stageM               (stageM),
    .pcCorrectE           (pcCorrectE),
    .predWrongE           (predWrongE),
    .instrMisalignedFaultM(instrMisalignedFaultM),
    .instrMisalignedAdrM  (instrMisalignedAdrM)
  );

endmodule

/* testbench/instrMem.sv */
module instrMem (
  input  logic            clk,
  input  ifuPkg::imemReqT req,
  output logic            ready,
  output ifuPkg::imemRspT rsp
);
  timeunit 1ns;
  timeprecision 1ps;
  import ifuPkg::*;

  localparam int depth = 4096;

  logic [15:0] parcels [depth];
  logic [11:0] idx;
  logic [11:0] idxNext;

  // halfword array, the index wraps at the top
  assign idx      = req.addr[12:1];
  assign idxNext  = idx + 12'd1;
  assign rsp.data = {parcels[idxNext], parcels[idx]};

  // random ready, about one cycle in four stalls
  initial ready = 1'b0;
  always @(posedge clk) begin
    #10;
    ready <= ($urandom % 4) != 0;
  end

  ////////////////////////////////////////
  // program image
  ////////////////////////////////////////

  task automatic preload();
    int          i;
    int          kind;
    logic [31:0] r;
    logic [6:0]  ops [8];
    ops = '{OP_BRANCH, OP_JAL, OP_JALR, OP_LUI, OP_OPIMM, OP_OP, OP_LOAD, OP_STORE};
    i = 0;
    while (i < depth) begin
      kind = $urandom % 32;
      r    = $urandom;
      if (kind == 0) begin
        // planted unsupported encodings, c.flw space or all zero
        parcels[i] = r[0] ? {3'b011, r[13:3], 2'b00} : 16'h0000;
        i++;
      end else if (kind < 18 || i == depth - 1) begin
        // supported funct3/quadrant pairs with random fields
        case (r[31:28] % 10)
          0: parcels[i] = {3'b010, r[10:0], 2'b00};
          1: parcels[i] = {3'b110, r[10:0], 2'b00};
          2: parcels[i] = {3'b000, r[10:0], 2'b01};
          3: parcels[i] = {3'b001, r[10:0], 2'b01};
          4: parcels[i] = {3'b010, r[10:0], 2'b01};
          5: parcels[i] = {3'b011, r[10:0], 2'b01};
          6: parcels[i] = {3'b101, r[10:0], 2'b01};
          7: parcels[i] = {3'b110, r[10:0], 2'b01};
          8: parcels[i] = {3'b111, r[10:0], 2'b01};
          default: parcels[i] = {3'b100, r[10:0], 2'b10};
        endcase
        i++;
      end else begin
        // full word, low parcel first
        r[6:0]         = ops[$urandom % 8];
        parcels[i]     = r[15:0];
        parcels[i + 1] = r[31:16];
        i += 2;
      end
    end
  endtask

endmodule

/* testbench/ifuTb.sv */
module ifuTb;
  timeunit 1ns;
  timeprecision 1ps;
  import ifuPkg::*;

  localparam logic [XLEN-1:0] resetVector = 32'h8000_0000;
  localparam int testLen = 400;
  localparam int timeoutCycles = 16 + testLen * 4;

  logic clk = 1'b0;
  logic rst, stallF, stallD, stallE, stallM, flushD, flushE, flushM;
  logic pcSrcE, retM, trapM, imemValid, imemReady;
  logic [XLEN-1:0] pcTargetE, privNextPcM, pcF, instrMisalignedAdrM;
  logic predWrongE, illegalCompD, instrMisalignedFaultM;
  imemReqT imemReq;
  imemRspT imemRsp;
  stageT stageD, stageE, stageM;

  int errStage = 0;
  int errFlag = 0;
  int errAddr = 0;
  int mCount = 0;
  int cycles = 0;
  int redirAfter = 0;
  bit mHeld = 1'b0;
  bit rstLast = 1'b1;
  bit expFault = 1'b0;
  logic [XLEN-1:0] expAdr;
  logic [XLEN-1:0] expPc = resetVector;
  logic [XLEN-1:0] redirTarget;

  always #50 clk = ~clk;

  ifu #(.resetVector(resetVector)) UUT (.*);

  instrMem imem (.clk(clk), .req(imemReq), .ready(imemReady), .rsp(imemRsp));

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] encodeJal(int off, logic [4:0] rd);
    logic [31:0] v;
    v = off;
    return {v[20], v[10:1], v[11], v[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [31:0] encodeBranch(int off, logic [4:0] rs1, logic [2:0] f3);
    logic [31:0] v;
    v = off;
    return {v[12], v[10:5], 5'd0, rs1, f3, v[4:1], v[11], OP_BRANCH};
  endfunction

  // bit 32 flags an unsupported encoding, the word is then NOP
  function automatic logic [32:0] refExpand(logic [15:0] c);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [31:0] v;
    logic [31:0] w;
    int          imm;
    int          mem;
    int          jo;
    int          bo;
    logic        bad;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = 5'd8 + c[4:2];
    rs1p = 5'd8 + c[9:7];
    imm  = int'(c[6:2]) - (c[12] ? 32 : 0);
    v    = imm;
    mem  = (int'(c[5]) << 6) | (int'(c[12:10]) << 3) | (int'(c[6]) << 2);
    jo   = (int'(c[5:3]) << 1) | (int'(c[11]) << 4) | (int'(c[2]) << 5) | (int'(c[7]) << 6)
         | (int'(c[6]) << 7) | (int'(c[10:9]) << 8) | (int'(c[8]) << 10);
    jo   = jo - (c[12] ? 2048 : 0);
    bo   = (int'(c[4:3]) << 1) | (int'(c[11:10]) << 3) | (int'(c[2]) << 5)
         | (int'(c[6:5]) << 6);
    bo   = bo - (c[12] ? 256 : 0);
    w    = NOP;
    bad  = 1'b0;
    case ({c[1:0], c[15:13]})
      5'b00_010: w = {mem[11:0], rs1p, 3'b010, rdp, OP_LOAD};
      5'b00_110: w = {7'(mem >> 5), rdp, rs1p, 3'b010, mem[4:0], OP_STORE};
      5'b01_000: w = {v[11:0], rd, 3'b000, rd, OP_OPIMM};
      5'b01_001: w = encodeJal(jo, 5'd1);
      5'b01_010: w = {v[11:0], 5'd0, 3'b000, rd, OP_OPIMM};
      5'b01_011: begin
        if (rd == 5'd2 || imm == 0) bad = 1'b1;
        else w = {v[19:0], rd, OP_LUI};
      end
      5'b01_101: w = encodeJal(jo, 5'd0);
      5'b01_110: w = encodeBranch(bo, rs1p, 3'b000);
      5'b01_111: w = encodeBranch(bo, rs1p, 3'b001);
      5'b10_100: begin
        if (rs2 != 0) w = {7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, OP_OP};
        else if (rd == 0) bad = 1'b1;
        else w = {12'd0, rd, 3'b000, c[12] ? 5'd1 : 5'd0, OP_JALR};
      end
      default: bad = 1'b1;
    endcase
    return {bad, w};
  endfunction

  function automatic instrClassT refClass(logic [31:0] w);
    instrClassT k;
    bit jal;
    bit jalr;
    bit rdLink;
    bit rs1Link;
    jal       = w[6:0] == OP_JAL;
    jalr      = w[6:0] == OP_JALR;
    rdLink    = w[11:7] == 5'd1 || w[11:7] == 5'd5;
    rs1Link   = w[19:15] == 5'd1 || w[19:15] == 5'd5;
    k.call    = (jal || jalr) && rdLink;
    k.ret     = jalr && rs1Link && !rdLink;
    k.jumpReg = jalr && !k.call && !k.ret;
    k.jump    = jal && !rdLink;
    k.branch  = w[6:0] == OP_BRANCH;
    return k;
  endfunction

  function automatic logic [15:0] readParcel(logic [XLEN-1:0] a);
    return imem.parcels[a[12:1]];
  endfunction

  function automatic logic [31:0] expectedWord(logic [XLEN-1:0] a);
    logic [15:0] lo;
    logic [32:0] x;
    lo = readParcel(a);
    if (lo[1:0] == 2'b11) return {readParcel(a + 2), lo};
    x = refExpand(lo);
    return x[31:0];
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic checkStage(stageT got, stageT exp, string what);
    if (got !== exp) begin
      errStage++;
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(bit got, bit exp, string what);
    if (got !== exp) begin
      errFlag++;
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkAddr(logic [XLEN-1:0] got, logic [XLEN-1:0] exp, string what);
    if (got !== exp) begin
      errAddr++;
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // compare process, mid-cycle when every output has settled
  always @(negedge clk) begin
    stageT e;
    logic [15:0] lo;
    logic [32:0] x;
    bit expIll;
    // no fetch request in reset or in the delayed reset cycle
    checkFlag(imemValid, !rst && !rstLast, "imemValid");
    if (!rst) begin
      checkFlag(predWrongE, pcSrcE, "predWrongE");
      lo     = readParcel(stageD.pc);
      x      = refExpand(lo);
      expIll = stageD.valid && lo[1:0] != 2'b11 && x[32];
      checkFlag(illegalCompD, expIll, "illegalCompD");
      if (expIll) checkAddr(stageD.instr, NOP, "stageD NOP on illegal");
      // a held M entry was already seen
      if (stageM.valid && !mHeld) begin
        e.valid  = 1'b1;
        e.pc     = expPc;
        e.instr  = expectedWord(expPc);
        e.pcLink = expPc + (readParcel(expPc) ==? 16'b??????????????11 ? 4 : 2);
        e.cls    = refClass(e.instr);
        checkStage(stageM, e, "stageM");
        mCount++;
        expPc = e.pcLink;
        if (redirAfter > 0) begin
          redirAfter--;
          if (redirAfter == 0) expPc = redirTarget;
        end
      end
    end else if (cycles > 0) begin
      // every register has seen a reset edge by now
      checkAddr(pcF, resetVector, "pcF in reset");
      checkFlag(stageD.valid, 1'b0, "stageD.valid in reset");
      checkFlag(stageE.valid, 1'b0, "stageE.valid in reset");
      checkFlag(stageM.valid, 1'b0, "stageM.valid in reset");
      checkFlag(illegalCompD, 1'b0, "illegalCompD in reset");
      checkFlag(instrMisalignedFaultM, 1'b0, "instrMisalignedFaultM in reset");
    end
    mHeld   = stallM;
    rstLast = rst;
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    int r;
    int lvl;
    logic [XLEN-1:0] tgt;
    bit redirNow;
    void'($urandom(32'h1009));
    imem.preload();
    {rst, stallF, stallD, stallE, stallM, flushD, flushE, flushM} = 8'h80;
    {pcSrcE, retM, trapM} = 3'b000;
    pcTargetE   = '0;
    privNextPcM = '0;
    redirNow    = 1'b0;
    repeat (16) @(posedge clk);
    #10;
    rst = 1'b0;
    while (mCount < testLen) begin
      @(posedge clk);
      #10;
      checkFlag(instrMisalignedFaultM, expFault, "instrMisalignedFaultM");
      if (expFault) checkAddr(instrMisalignedAdrM, expAdr, "instrMisalignedAdrM");
      if (redirNow) begin
        // target in pcF one edge later, D and E emptied
        checkAddr(pcF, redirTarget, "pcF after redirect");
        checkFlag(stageD.valid, 1'b0, "stageD.valid after redirect");
        checkFlag(stageE.valid, 1'b0, "stageE.valid after flush");
      end
      redirNow = 1'b0;
      {stallF, stallD, stallE, stallM, flushD, flushE, flushM} = '0;
      {pcSrcE, retM, trapM} = 3'b000;
      r = $urandom % 16;
      if (mCount > 0 && r == 0) begin
        // redirect anywhere in the image, odd now and then
        tgt = resetVector + (($urandom % 4096) << 1) + (($urandom % 4) == 0);
        if ($urandom % 4 == 0) begin
          trapM       = 1'b1;
          privNextPcM = tgt;
        end else begin
          pcSrcE    = 1'b1;
          pcTargetE = tgt;
        end
        flushD      = 1'b1;
        flushE      = 1'b1;
        redirNow    = 1'b1;
        redirTarget = {tgt[XLEN-1:1], 1'b0};
        // entries in M and E still drain ahead of the target
        redirAfter  = int'(stageM.valid && !mHeld) + int'(stageE.valid);
        if (redirAfter == 0) expPc = redirTarget;
      end else if (r < 3) begin
        // stall a prefix of stages, bubble the one after
        lvl    = 1 + $urandom % 4;
        stallF = 1'b1;
        stallD = lvl > 1;
        stallE = lvl > 2;
        stallM = lvl > 3;
        flushE = lvl == 2;
        flushM = lvl == 3;
      end
      if (!stallM) begin
        expFault = pcSrcE && pcTargetE[0];
        expAdr   = pcTargetE;
      end
    end
    $display("errors: stage %0d, flag %0d, addr %0d", errStage, errFlag, errAddr);
    if (errStage + errFlag + errAddr == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // run limit from reset plus four cycles per checked entry
  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeoutCycles) begin
      $display("timeout: only %0d of %0d stageM entries after %0d cycles",
               mCount, testLen, cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

/* src.f */
hdl/ifuPkg.sv
hdl/pcLogic.sv
hdl/decompress.sv
hdl/decodeStage.sv
hdl/execMemPipe.sv
hdl/ifu.sv
testbench/instrMem.sv
testbench/ifuTb.sv

/* run.sh */
#!/bin/sh
# build and run the IFU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module ifuTb -f src.f -o ifuSim
./obj_dir/ifuSim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
